// ==== load_queue.sv ====
// load queue with issue and cdb result slot

`timescale 1ns/1ns
`include "lsq_config.svh"

module load_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                alloc,
	input  lsq_pkg::lq_entry_t  entry_in,
	input  logic                cdb_valid,
	input  lsq_pkg::prf_tag_t   cdb_tag,
	input  lsq_pkg::word_t      cdb_data,
	input  logic                mem_load_valid,
	input  lsq_pkg::mem_tag_t   mem_load_tag,
	input  lsq_pkg::word_t      mem_load_data,
	input  logic                commit_valid,
	input  lsq_pkg::rob_idx_t   commit_rob_idx,
	output logic                full,
	output logic                lsq_cdb_valid,
	output lsq_pkg::prf_tag_t   lsq_cdb_tag,
	output lsq_pkg::word_t      lsq_cdb_data,
	output logic                mem_load_req,
	output lsq_pkg::word_t      mem_load_addr,
	output lsq_pkg::mem_tag_t   mem_load_req_tag,
	lsq_search_if.lq            search
);
	import lsq_pkg::*;

	localparam int IDX_W = $clog2(`LQ_SIZE);
	localparam int TAG_W = $bits(prf_tag_t);

	lq_entry_t [`LQ_SIZE-1:0]  entries;
	logic [`LQ_SIZE-1:0]       busy;
	logic [IDX_W-1:0]          free_idx;
	logic [IDX_W-1:0]          sel_idx;
	logic [IDX_W-1:0]          resp_idx;
	logic                      sel_found;
	logic                      resp_hit;
	logic                      fwd;
	logic                      miss;
	mem_tag_t                  next_tag;    // wrapping request tag

	// descending scan so the lowest slot wins
	always_comb begin
		free_idx  = '0;
		sel_idx   = '0;
		sel_found = 1'b0;
		resp_idx  = '0;
		resp_hit  = 1'b0;
		for (int i = `LQ_SIZE - 1; i >= 0; i--) begin
			busy[i] = entries[i].valid;
			if (!entries[i].valid)
				free_idx = IDX_W'(i);
			if (entries[i].valid && entries[i].addr_valid &&
				!entries[i].waiting_mem && !entries[i].done) begin
				sel_idx   = IDX_W'(i);
				sel_found = 1'b1;
			end
			if (mem_load_valid && entries[i].valid && entries[i].waiting_mem &&
				entries[i].mem_tag == mem_load_tag) begin
				resp_idx = IDX_W'(i);
				resp_hit = 1'b1;
			end
		end
	end

	assign full = &busy;

	assign search.req       = sel_found;
	assign search.load_addr = entries[sel_idx].addr;
	assign search.limit     = entries[sel_idx].sq_tail;

	assign fwd  = sel_found && search.hit;
	assign miss = sel_found && !search.hit && !search.blocked;

	always_ff @(posedge clock) begin
		if (reset) begin
			lsq_cdb_valid <= 1'b0;
			mem_load_req  <= 1'b0;
			next_tag      <= '0;
			for (int i = 0; i < `LQ_SIZE; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `LQ_SIZE; i++) begin
				if (entries[i].valid) begin
					if (!entries[i].offset.valid && cdb_valid &&
						entries[i].offset.value[TAG_W-1:0] == cdb_tag) begin
						entries[i].offset     <= {1'b1, cdb_data};
						entries[i].addr       <= entries[i].base + cdb_data;
						entries[i].addr_valid <= 1'b1;
					end
					if (commit_valid && entries[i].rob_idx == commit_rob_idx)
						entries[i].valid <= 1'b0;    // retired
				end
			end

			if (alloc && !full)
				entries[free_idx] <= entry_in;

			//////////////////////////////////////////////////////////////////////
			// cdb slot, memory response first, a losing forward retries
			lsq_cdb_valid <= resp_hit || fwd;
			if (resp_hit) begin
				lsq_cdb_tag                   <= entries[resp_idx].dest_tag;
				lsq_cdb_data                  <= mem_load_data;
				entries[resp_idx].waiting_mem <= 1'b0;
				entries[resp_idx].done        <= 1'b1;
			end else if (fwd) begin
				lsq_cdb_tag           <= entries[sel_idx].dest_tag;
				lsq_cdb_data          <= search.hit_data;
				entries[sel_idx].done <= 1'b1;
			end

			mem_load_req <= miss;
			if (miss) begin
				mem_load_addr                <= entries[sel_idx].addr;
				mem_load_req_tag             <= next_tag;
				entries[sel_idx].waiting_mem <= 1'b1;
				entries[sel_idx].mem_tag     <= next_tag;
				next_tag                     <= next_tag + 1'b1;
			end
		end
	end

endmodule

// ==== lsq.sv ====
// load/store queue top

`timescale 1ns/1ns

module lsq (
	input  logic               clock,
	input  logic               reset,
	input  logic               disp_load,
	input  logic               disp_store,
	input  lsq_pkg::word_t     disp_base,
	input  lsq_pkg::word_t     disp_offset,
	input  logic               disp_offset_valid,
	input  lsq_pkg::word_t     disp_data,
	input  logic               disp_data_valid,
	input  lsq_pkg::rob_idx_t  disp_rob_idx,
	input  lsq_pkg::prf_tag_t  disp_dest_tag,
	input  logic               cdb_valid,
	input  lsq_pkg::prf_tag_t  cdb_tag,
	input  lsq_pkg::word_t     cdb_data,
	input  logic               commit_valid,
	input  lsq_pkg::rob_idx_t  commit_rob_idx,
	input  logic               mem_load_valid,
	input  lsq_pkg::mem_tag_t  mem_load_tag,
	input  lsq_pkg::word_t     mem_load_data,
	output logic               lq_full,
	output logic               sq_full,
	output logic               lsq_cdb_valid,
	output lsq_pkg::prf_tag_t  lsq_cdb_tag,
	output lsq_pkg::word_t     lsq_cdb_data,
	output logic               mem_load_req,
	output lsq_pkg::word_t     mem_load_addr,
	output lsq_pkg::mem_tag_t  mem_load_req_tag,
	output logic               mem_store_valid,
	output lsq_pkg::word_t     mem_store_addr,
	output lsq_pkg::word_t     mem_store_data
);
	import lsq_pkg::*;

	operand_t   offset_cap;
	operand_t   data_cap;
	word_t      eff_addr;
	sq_idx_t    sq_tail;
	sq_entry_t  sq_new;
	lq_entry_t  lq_new;

	lsq_search_if search_bus ();

	operand_capture u_capture (
		.disp_base   (disp_base),
		.disp_offset ({disp_offset_valid, disp_offset}),
		.disp_data   ({disp_data_valid, disp_data}),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data),
		.offset_out  (offset_cap),
		.data_out    (data_cap),
		.addr        (eff_addr)
	);

	// new entries from the captured operands
	always_comb begin
		sq_new            = '0;
		sq_new.valid      = 1'b1;
		sq_new.addr       = eff_addr;
		sq_new.addr_valid = offset_cap.valid;
		sq_new.base       = disp_base;
		sq_new.offset     = offset_cap;
		sq_new.data       = data_cap;
		sq_new.rob_idx    = disp_rob_idx;

		lq_new            = '0;
		lq_new.valid      = 1'b1;
		lq_new.addr       = eff_addr;
		lq_new.addr_valid = offset_cap.valid;
		lq_new.base       = disp_base;
		lq_new.offset     = offset_cap;
		lq_new.dest_tag   = disp_dest_tag;
		lq_new.rob_idx    = disp_rob_idx;
		lq_new.sq_tail    = sq_tail;    // stores before this load
	end

	store_queue u_sq (
		.clock           (clock),
		.reset           (reset),
		.alloc           (disp_store),
		.entry_in        (sq_new),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.cdb_data        (cdb_data),
		.commit_valid    (commit_valid),
		.commit_rob_idx  (commit_rob_idx),
		.tail            (sq_tail),
		.full            (sq_full),
		.mem_store_valid (mem_store_valid),
		.mem_store_addr  (mem_store_addr),
		.mem_store_data  (mem_store_data),
		.search          (search_bus.sq)
	);

	store_forward_search u_search (
		.search (search_bus.result)
	);

	load_queue u_lq (
		.clock            (clock),
		.reset            (reset),
		.alloc            (disp_load),
		.entry_in         (lq_new),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_data         (cdb_data),
		.mem_load_valid   (mem_load_valid),
		.mem_load_tag     (mem_load_tag),
		.mem_load_data    (mem_load_data),
		.commit_valid     (commit_valid),
		.commit_rob_idx   (commit_rob_idx),
		.full             (lq_full),
		.lsq_cdb_valid    (lsq_cdb_valid),
		.lsq_cdb_tag      (lsq_cdb_tag),
		.lsq_cdb_data     (lsq_cdb_data),
		.mem_load_req     (mem_load_req),
		.mem_load_addr    (mem_load_addr),
		.mem_load_req_tag (mem_load_req_tag),
		.search           (search_bus.lq)
	);

endmodule

// ==== lsq_cases.txt ====
# L base offset offset_valid rob dest | S base offset offset_valid data data_valid rob
# C tag data | M rob | N cycles quiet | Q mem requests so far | R tag data | D tag addr | W addr data
N 8
S 1000 10 1 cafe0001 1 1
L 1000 10 1 2 21
R 21 cafe0001
Q 0
M 2
L 2000 8 1 3 22
D 22 2008
Q 1
M 3
# store data pending on tag 7, younger load to the same address
S 3000 0 1 7 0 4
L 3000 0 1 5 23
N 6
C 7 beef0007
R 23 beef0007
M 5
# load offset pending on tag 9
L 4000 9 0 6 24
N 6
C 9 40
D 24 4040
Q 2
M 6
# store rob 7 is never committed
S 5000 8 1 5555 1 7
M 1
W 1010 cafe0001
M 4
W 3000 beef0007
N 10

// ==== lsq_config.svh ====
// load/store queue sizing

`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

`define LQ_SIZE    8    // load entries
`define SQ_SIZE    8    // store entries, power of two
`define ROB_SIZE   32
`define PRF_SIZE   64
`define MEM_TAG_W  5    // outstanding memory load tag
`define XLEN       64   // data and address width

`endif

// ==== lsq_pkg.sv ====
// load/store queue types

`include "lsq_config.svh"

package lsq_pkg;

	typedef logic [`XLEN-1:0]               word_t;
	typedef logic [$clog2(`PRF_SIZE)-1:0]   prf_tag_t;
	typedef logic [$clog2(`ROB_SIZE)-1:0]   rob_idx_t;
	typedef logic [$clog2(`SQ_SIZE):0]      sq_idx_t;   // top bit is the wrap bit
	typedef logic [`MEM_TAG_W-1:0]          mem_tag_t;

	// value is data when valid, otherwise a prf tag in the low bits
	typedef struct packed {
		logic  valid;
		word_t value;
	} operand_t;

	typedef struct packed {
		logic     valid;
		word_t    addr;
		logic     addr_valid;
		word_t    base;
		operand_t offset;
		operand_t data;
		rob_idx_t rob_idx;
		logic     committed;
	} sq_entry_t;

	typedef struct packed {
		logic     valid;
		word_t    addr;
		logic     addr_valid;
		word_t    base;
		operand_t offset;
		prf_tag_t dest_tag;
		rob_idx_t rob_idx;
		sq_idx_t  sq_tail;      // store queue tail at dispatch
		logic     waiting_mem;
		mem_tag_t mem_tag;
		logic     done;
	} lq_entry_t;

endpackage

// ==== lsq_search_if.sv ====
// store forward search bus

`timescale 1ns/1ns
`include "lsq_config.svh"

interface lsq_search_if;
	import lsq_pkg::*;

	// load side request
	logic                      req;
	word_t                     load_addr;
	sq_idx_t                   limit;     // older stores end here

	// store queue state
	sq_entry_t [`SQ_SIZE-1:0]  entries;
	sq_idx_t                   head;
	sq_idx_t                   tail;

	// answer, same cycle as req
	logic                      hit;
	logic                      blocked;
	word_t                     hit_data;

	modport lq (output req, load_addr, limit, input hit, blocked, hit_data);

	modport sq (output entries, head, tail);

	modport result (
		input  req, load_addr, limit, entries, head, tail,
		output hit, blocked, hit_data
	);

endinterface

// ==== operand_capture.sv ====
// dispatch operand bypass from the cdb

`timescale 1ns/1ns

module operand_capture (
	input  lsq_pkg::word_t     disp_base,
	input  lsq_pkg::operand_t  disp_offset,
	input  lsq_pkg::operand_t  disp_data,
	input  logic               cdb_valid,
	input  lsq_pkg::prf_tag_t  cdb_tag,
	input  lsq_pkg::word_t     cdb_data,
	output lsq_pkg::operand_t  offset_out,
	output lsq_pkg::operand_t  data_out,
	output lsq_pkg::word_t     addr
);
	import lsq_pkg::*;

	localparam int TAG_W = $bits(prf_tag_t);

	// swap a pending tag for the broadcast value
	function automatic operand_t capture(
		input operand_t op,
		input logic     bus_valid,
		input prf_tag_t bus_tag,
		input word_t    bus_data
	);
		operand_t res;
		res = op;
		if (!op.valid && bus_valid && op.value[TAG_W-1:0] == bus_tag) begin
			res.valid = 1'b1;
			res.value = bus_data;
		end
		return res;
	endfunction

	assign offset_out = capture(disp_offset, cdb_valid, cdb_tag, cdb_data);
	assign data_out   = capture(disp_data, cdb_valid, cdb_tag, cdb_data);

	// only meaningful once offset_out.valid
	assign addr = disp_base + offset_out.value;

endmodule

// ==== store_forward_search.sv ====
// youngest older store match for a load

`timescale 1ns/1ns
`include "lsq_config.svh"

module store_forward_search (
	lsq_search_if.result search
);
	import lsq_pkg::*;

	localparam int PTR_W = $clog2(`SQ_SIZE);

	sq_idx_t           count;        // stores older than the load
	logic [PTR_W-1:0]  slot;
	logic              unknown;      // some older address not known yet
	logic              match;
	logic              match_ready;
	word_t             match_data;

	always_comb begin
		// head never passes the load's snapshot while it is searching
		count       = (search.head == search.tail) ? '0 : search.limit - search.head;
		slot        = '0;
		unknown     = 1'b0;
		match       = 1'b0;
		match_ready = 1'b0;
		match_data  = '0;
		for (int k = 0; k < `SQ_SIZE; k++) begin
			slot = search.head[PTR_W-1:0] + PTR_W'(k);
			if (k < count && search.entries[slot].valid) begin
				if (!search.entries[slot].addr_valid) begin
					unknown = 1'b1;
				end else if (search.entries[slot].addr == search.load_addr) begin
					match       = 1'b1;    // later k is younger, overwrite
					match_ready = search.entries[slot].data.valid;
					match_data  = search.entries[slot].data.value;
				end
			end
		end
	end

	assign search.blocked  = search.req && (unknown || (match && !match_ready));
	assign search.hit      = search.req && !unknown && match && match_ready;
	assign search.hit_data = match_data;

endmodule

// ==== store_queue.sv ====
// in-order store queue

`timescale 1ns/1ns
`include "lsq_config.svh"

module store_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                alloc,
	input  lsq_pkg::sq_entry_t  entry_in,
	input  logic                cdb_valid,
	input  lsq_pkg::prf_tag_t   cdb_tag,
	input  lsq_pkg::word_t      cdb_data,
	input  logic                commit_valid,
	input  lsq_pkg::rob_idx_t   commit_rob_idx,
	output lsq_pkg::sq_idx_t    tail,
	output logic                full,
	output logic                mem_store_valid,
	output lsq_pkg::word_t      mem_store_addr,
	output lsq_pkg::word_t      mem_store_data,
	lsq_search_if.sq            search
);
	import lsq_pkg::*;

	localparam int PTR_W = $clog2(`SQ_SIZE);
	localparam int TAG_W = $bits(prf_tag_t);

	sq_entry_t [`SQ_SIZE-1:0]  entries;
	sq_idx_t                   head;
	logic [PTR_W-1:0]          head_slot;
	logic [PTR_W-1:0]          tail_slot;
	logic                      drain;

	assign head_slot = head[PTR_W-1:0];
	assign tail_slot = tail[PTR_W-1:0];
	assign full      = (head_slot == tail_slot) && (head[PTR_W] != tail[PTR_W]);

	// head leaves once retired and fully resolved
	assign drain = entries[head_slot].valid && entries[head_slot].committed &&
		entries[head_slot].addr_valid && entries[head_slot].data.valid;

	assign search.entries = entries;
	assign search.head    = head;
	assign search.tail    = tail;

	always_ff @(posedge clock) begin
		if (reset) begin
			head            <= '0;
			tail            <= '0;
			mem_store_valid <= 1'b0;
			for (int i = 0; i < `SQ_SIZE; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			//////////////////////////////////////////////////////////////////////
			// cdb snoop and commit marking
			for (int i = 0; i < `SQ_SIZE; i++) begin
				if (entries[i].valid) begin
					if (!entries[i].offset.valid && cdb_valid &&
						entries[i].offset.value[TAG_W-1:0] == cdb_tag) begin
						entries[i].offset     <= {1'b1, cdb_data};
						entries[i].addr       <= entries[i].base + cdb_data;
						entries[i].addr_valid <= 1'b1;
					end
					if (!entries[i].data.valid && cdb_valid &&
						entries[i].data.value[TAG_W-1:0] == cdb_tag) begin
						entries[i].data <= {1'b1, cdb_data};
					end
					if (commit_valid && entries[i].rob_idx == commit_rob_idx)
						entries[i].committed <= 1'b1;
				end
			end

			if (alloc && !full) begin
				entries[tail_slot] <= entry_in;
				tail               <= tail + 1'b1;
			end

			//////////////////////////////////////////////////////////////////////
			// drain head to memory
			mem_store_valid <= drain;
			if (drain) begin
				mem_store_addr           <= entries[head_slot].addr;
				mem_store_data           <= entries[head_slot].data.value;
				entries[head_slot].valid <= 1'b0;
				head                     <= head + 1'b1;
			end
		end
	end

endmodule

// ==== tb_lsq.sv ====
// load/store queue testbench

`timescale 1ns/1ns
`include "lsq_config.svh"

module tb_lsq;
	import lsq_pkg::*;

	localparam logic [63:0] MEM_XOR    = 64'h5a5a_0000_0000_5a5a;
	localparam int          WAIT_LIMIT = 100;    // cycles per wait loop

	logic clock = 1'b0;
	logic reset;
	logic disp_load, disp_store, disp_offset_valid, disp_data_valid;
	word_t disp_base, disp_offset, disp_data;
	rob_idx_t disp_rob_idx, commit_rob_idx;
	prf_tag_t disp_dest_tag, cdb_tag, lsq_cdb_tag;
	logic cdb_valid, commit_valid, mem_load_valid;
	word_t cdb_data, mem_load_data;
	mem_tag_t mem_load_tag, mem_load_req_tag;
	logic lq_full, sq_full, lsq_cdb_valid, mem_load_req, mem_store_valid;
	word_t lsq_cdb_data, mem_load_addr, mem_store_addr, mem_store_data;

	word_t res_tag[$];      // observed cdb results
	word_t res_data[$];
	word_t wr_addr[$];      // observed store writes
	word_t wr_data[$];
	mem_tag_t pend_tag[$];  // memory answers in flight
	word_t pend_data[$];
	int pend_due[$];
	int last_due = 0;
	int req_count = 0;
	int cycle = 0;
	logic [31:0] lfsr = 32'hfe57_5713;

	always #2 clock = ~clock;

	lsq UUT (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32+x^22+x^2+x+1
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic step_cycle();
		@(posedge clock);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// output monitor and memory model sampled mid-cycle
	always @(negedge clock) begin
		logic [1:0] d;
		int due;
		cycle++;
		if (!reset) begin
			if (lsq_cdb_valid) begin
				res_tag.push_back(word_t'(lsq_cdb_tag));
				res_data.push_back(lsq_cdb_data);
			end
			if (mem_store_valid) begin
				wr_addr.push_back(mem_store_addr);
				wr_data.push_back(mem_store_data);
			end
			if (mem_load_req) begin
				req_count++;
				lfsr = lfsr_next(lfsr);
				d[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				d[1] = lfsr[0];
				due = cycle + int'(d) + 1;
				if (due <= last_due)
					due = last_due + 1;    // one answer per cycle and in order
				last_due = due;
				pend_tag.push_back(mem_load_req_tag);
				pend_data.push_back(mem_load_addr ^ MEM_XOR);
				pend_due.push_back(due);
			end
		end
	end

	always @(posedge clock) begin
		#1;
		if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
			mem_load_valid = 1'b1;
			mem_load_tag   = pend_tag.pop_front();
			mem_load_data  = pend_data.pop_front();
			void'(pend_due.pop_front());
		end else begin
			mem_load_valid = 1'b0;
		end
	end

	task automatic wait_result(input logic [63:0] tag, input logic [63:0] data);
		int t;
		t = 0;
		while (res_tag.size() == 0) begin
			if (t == WAIT_LIMIT)
				fail_run("timed out waiting for a load result on the lsq cdb");
			step_cycle();
			t++;
		end
		check("lsq_cdb_tag", res_tag.pop_front(), tag);
		check("lsq_cdb_data", res_data.pop_front(), data);
	endtask

	task automatic wait_write(input logic [63:0] addr, input logic [63:0] data);
		int t;
		t = 0;
		while (wr_addr.size() == 0) begin
			if (t == WAIT_LIMIT)
				fail_run("timed out waiting for a store write to memory");
			step_cycle();
			t++;
		end
		check("mem_store_addr", wr_addr.pop_front(), addr);
		check("mem_store_data", wr_data.pop_front(), data);
	endtask

	// nothing may come out for n cycles
	task automatic expect_quiet(input int n);
		int base;
		base = req_count;
		repeat (n) step_cycle();
		check("lsq_cdb_valid", 64'(res_tag.size()), 64'd0);
		check("mem_store_valid", 64'(wr_addr.size()), 64'd0);
		check("mem_load_req", 64'(req_count), 64'(base));
		check("lq_full", 64'(lq_full), 64'd0);
		check("sq_full", 64'(sq_full), 64'd0);
	endtask

	task automatic run_step(input logic [7:0] op, input word_t f0, input word_t f1,
		input word_t f2, input word_t f3, input word_t f4, input word_t f5);
		case (op)
			"L": begin
				check("lq_full", 64'(lq_full), 64'd0);    // few loads in flight
				disp_load         = 1'b1;
				disp_base         = f0;
				disp_offset       = f1;
				disp_offset_valid = f2[0];
				disp_rob_idx      = rob_idx_t'(f3);
				disp_dest_tag     = prf_tag_t'(f4);
				step_cycle();
				disp_load = 1'b0;
			end
			"S": begin
				check("sq_full", 64'(sq_full), 64'd0);
				disp_store        = 1'b1;
				disp_base         = f0;
				disp_offset       = f1;
				disp_offset_valid = f2[0];
				disp_data         = f3;
				disp_data_valid   = f4[0];
				disp_rob_idx      = rob_idx_t'(f5);
				step_cycle();
				disp_store = 1'b0;
			end
			"C": begin
				cdb_valid = 1'b1;
				cdb_tag   = prf_tag_t'(f0);
				cdb_data  = f1;
				step_cycle();
				cdb_valid = 1'b0;
			end
			"M": begin
				commit_valid   = 1'b1;
				commit_rob_idx = rob_idx_t'(f0);
				step_cycle();
				commit_valid = 1'b0;
			end
			"R": wait_result(f0, f1);
			"D": wait_result(f0, f1 ^ MEM_XOR);    // value from memory
			"W": wait_write(f0, f1);
			"N": expect_quiet(int'(f0));
			"Q": check("mem_load_req", 64'(req_count), f0);
			default: fail_run("unknown step in lsq_cases.txt");
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// reset and then replay the case file
	initial begin
		string line;
		int fd;
		int n;
		logic [7:0] op;
		word_t f0, f1, f2, f3, f4, f5;
		reset             = 1'b1;
		disp_load         = 1'b0;
		disp_store        = 1'b0;
		disp_base         = '0;
		disp_offset       = '0;
		disp_offset_valid = 1'b0;
		disp_data         = '0;
		disp_data_valid   = 1'b0;
		disp_rob_idx      = '0;
		disp_dest_tag     = '0;
		cdb_valid         = 1'b0;
		cdb_tag           = '0;
		cdb_data          = '0;
		commit_valid      = 1'b0;
		commit_rob_idx    = '0;
		mem_load_valid    = 1'b0;
		mem_load_tag      = '0;
		mem_load_data     = '0;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;

		fd = $fopen("lsq_cases.txt", "r");
		if (fd == 0)
			fail_run("could not open lsq_cases.txt for reading");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				f0 = '0;
				f1 = '0;
				f2 = '0;
				f3 = '0;
				f4 = '0;
				f5 = '0;
				n = $sscanf(line, "%c %h %h %h %h %h %h", op, f0, f1, f2, f3, f4, f5);
				run_step(op, f0, f1, f2, f3, f4, f5);
			end
		end
		$fclose(fd);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
lsq_pkg.sv
lsq_search_if.sv
operand_capture.sv
store_queue.sv
store_forward_search.sv
load_queue.sv
lsq.sv
tb_lsq.sv
